// ==== Makefile ====
# Verilator build for the blimp core testbench

TOP := blimp_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		-f list.f --top-module $(TOP) -o $(TOP)

# Verdict comes from the log, not the exit code of the pipe
run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/blimp_core_tb.sv ====
// Blimp core testbench
// Wishbone instruction memory with random ack delay, program table with
// hand-computed commits, trace compared row by row in program order

`timescale 1ns/1ps
`default_nettype none

module blimp_core_tb;

  localparam int xlen           = blimp_isa_pkg::xlen;
  localparam int aw             = blimp_isa_pkg::reg_addr_w;
  localparam int n_rows         = 21;
  localparam int timeout_cycles = n_rows * 8 + 100;

  // Instruction word and the commit it must produce
  typedef struct packed {
    logic [xlen-1:0] inst;
    logic            wen;
    logic [aw-1:0]   waddr;
    logic [xlen-1:0] wdata;
  } commit_row_t;

  commit_row_t rows [n_rows];

  logic            clk;
  logic            rst_n;
  logic            inst_cyc;
  logic            inst_stb;
  logic [xlen-1:0] inst_adr;
  logic [xlen-1:0] inst_dat = '0;
  logic            inst_ack = 1'b0;
  logic            trace_val;
  logic [xlen-1:0] trace_pc;
  logic            trace_wen;
  logic [aw-1:0]   trace_waddr;
  logic [xlen-1:0] trace_wdata;

  int          ack_wait     = 0;
  int          cycle_cnt    = 0;
  int          cur_row      = 0;
  int          commits_seen = 0;

  clock_gen #(.p_period_ns(4), .p_reset_cycles(16)) clk_i (.clk(clk), .rst_n(rst_n));

  blimp_core dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .inst_cyc    (inst_cyc),
    .inst_stb    (inst_stb),
    .inst_adr    (inst_adr),
    .inst_dat    (inst_dat),
    .inst_ack    (inst_ack),
    .trace_val   (trace_val),
    .trace_pc    (trace_pc),
    .trace_wen   (trace_wen),
    .trace_waddr (trace_waddr),
    .trace_wdata (trace_wdata)
  );

  //--------------------------------------------------------------------------
  // Program and expected commits
  //--------------------------------------------------------------------------

  task automatic load_table();
    rows[0]  = '{32'h2100_0005, 1'b1, 4'd1,  32'h0000_0005}; // addi r1, r0, 5
    rows[1]  = '{32'h2200_FFFD, 1'b1, 4'd2,  32'hFFFF_FFFD}; // addi r2, r0, -3
    rows[2]  = '{32'h2300_7FFF, 1'b1, 4'd3,  32'h0000_7FFF}; // addi r3, r0, 0x7fff
    rows[3]  = '{32'h1412_0000, 1'b1, 4'd4,  32'h0000_0002}; // add r4, r1, r2
    rows[4]  = '{32'h2500_8000, 1'b1, 4'd5,  32'hFFFF_8000}; // addi r5, r0, -32768
    rows[5]  = '{32'h3633_0000, 1'b1, 4'd6,  32'h3FFF_0001}; // mul r6, r3, r3
    rows[6]  = '{32'h3766_0000, 1'b1, 4'd7,  32'h7FFE_0001}; // mul r7, r6, r6 overflows
    rows[7]  = '{32'h1875_0000, 1'b1, 4'd8,  32'h7FFD_8001}; // add r8, r7, r5 wraps
    rows[8]  = '{32'h3925_0000, 1'b1, 4'd9,  32'h0001_8000}; // mul r9, r2, r5
    rows[9]  = '{32'h2010_0007, 1'b0, 4'd0,  32'h0000_0000}; // addi r0, r1, 7 dropped
    rows[10] = '{32'h1A01_0000, 1'b1, 4'd10, 32'h0000_0005}; // add r10, r0, r1
    rows[11] = '{32'h0000_0000, 1'b0, 4'd0,  32'h0000_0000}; // nop
    rows[12] = '{32'hF123_4567, 1'b0, 4'd0,  32'h0000_0000}; // undefined opcode
    rows[13] = '{32'h2BA0_0001, 1'b1, 4'd11, 32'h0000_0006}; // addi r11, r10, 1
    rows[14] = '{32'h3C41_0000, 1'b1, 4'd12, 32'h0000_000A}; // mul r12, r4, r1
    rows[15] = '{32'h2DC0_FFFF, 1'b1, 4'd13, 32'h0000_0009}; // addi r13, r12, -1
    rows[16] = '{32'h3ED8_0000, 1'b1, 4'd14, 32'h7FE9_8009}; // mul r14, r13, r8
    rows[17] = '{32'h1FE9_0000, 1'b1, 4'd15, 32'h7FEB_0009}; // add r15, r14, r9
    rows[18] = '{32'h8312_0000, 1'b0, 4'd0,  32'h0000_0000}; // undefined, rd set
    rows[19] = '{32'h31F0_0000, 1'b1, 4'd1,  32'h0000_0000}; // mul r1, r15, r0
    rows[20] = '{32'h1213_0000, 1'b1, 4'd2,  32'h0000_7FFF}; // add r2, r1, r3
  endtask

  //--------------------------------------------------------------------------
  // Instruction memory, Wishbone classic slave
  //--------------------------------------------------------------------------

  // Row i lives at 4*i, nop everywhere past the program
  function automatic logic [xlen-1:0] word_at(input logic [xlen-1:0] adr);
    int unsigned idx;
    idx = adr >> 2;
    if (idx < n_rows) return rows[idx].inst;
    return {blimp_isa_pkg::op_nop, 28'h0};
  endfunction

  // Ack after 0 to 3 wait cycles, dropped again the cycle after
  always @(posedge clk) begin
    if (!rst_n) begin
      inst_ack <= 1'b0;
      inst_dat <= '0;
      ack_wait <= int'($urandom % 4);
    end else if (inst_ack) begin
      inst_ack <= 1'b0;
    end else if (inst_cyc && inst_stb) begin
      if (ack_wait == 0) begin
        inst_ack <= 1'b1;
        inst_dat <= word_at(inst_adr);
        ack_wait <= int'($urandom % 4);
      end else begin
        ack_wait <= ack_wait - 1;
      end
    end
  end

  //--------------------------------------------------------------------------
  // Compare tasks and failure path
  //--------------------------------------------------------------------------

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_data(input string name, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] exp);
    if (got !== exp)
      report_failure($sformatf("CHECK FAILED row %0d: %s = 0x%h, expected 0x%h",
                               cur_row, name, got, exp));
  endtask

  task automatic check_addr(input string name, input logic [aw-1:0] got,
                            input logic [aw-1:0] exp);
    if (got !== exp)
      report_failure($sformatf("CHECK FAILED row %0d: %s = 0x%h, expected 0x%h",
                               cur_row, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("CHECK FAILED row %0d: %s = 0x%h, expected 0x%h",
                               cur_row, name, got, exp));
  endtask

  // Sample away from the rising edge, outputs settled by then
  task automatic wait_commit();
    @(negedge clk);
    while (trace_val !== 1'b1) @(negedge clk);
  endtask

  // Whole run bounded by program length
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles)
      report_failure($sformatf("Timeout after %0d cycles: only %0d of %0d commits seen",
                               cycle_cnt, commits_seen, n_rows));
  end

  //--------------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------------

  initial begin
    void'($urandom(94));
    load_table();
    for (cur_row = 0; cur_row < n_rows; cur_row++) begin
      wait_commit();
      commits_seen++;
      // Consecutive pcs mean nothing skipped or repeated
      check_data("trace_pc", trace_pc, 32'(cur_row * 4));
      check_bit("trace_wen", trace_wen, rows[cur_row].wen);
      if (rows[cur_row].wen) begin
        check_addr("trace_waddr", trace_waddr, rows[cur_row].waddr);
        check_data("trace_wdata", trace_wdata, rows[cur_row].wdata);
      end
    end
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/clock_gen.sv ====
// Testbench clock and reset source
// Free-running clock, active-low reset held for a fixed number of cycles

`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int p_period_ns    = 4,
  parameter int p_reset_cycles = 16
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(p_period_ns / 2) clk = ~clk;
  end

  // Release on a rising edge, like any other stimulus
  initial begin
    rst_n = 1'b0;
    repeat (p_reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== list.f ====
source/blimp_isa_pkg.sv
source/blimp_uarch_pkg.sv
source/fetch_decode_if.sv
source/fetch_unit.sv
source/inst_queue.sv
source/execute_commit_unit.sv
source/blimp_core.sv
dv/clock_gen.sv
dv/blimp_core_tb.sv

// ==== source/blimp_core.sv ====
// Blimp core top level
// Fetch, instruction queue and execute-commit joined by two valid/ready
// channels, Wishbone instruction port and commit trace as plain ports

`timescale 1ns/1ps
`default_nettype none

module blimp_core #(
  parameter int                             p_queue_depth = 4,
  parameter logic [blimp_isa_pkg::xlen-1:0] p_reset_pc    = '0
) (
  input  logic                                 clk,
  input  logic                                 rst_n,

  // Instruction memory, Wishbone classic read
  output logic                                 inst_cyc,
  output logic                                 inst_stb,
  output logic [blimp_isa_pkg::xlen-1:0]       inst_adr,
  input  logic [blimp_isa_pkg::xlen-1:0]       inst_dat,
  input  logic                                 inst_ack,

  // Commit trace
  output logic                                 trace_val,
  output logic [blimp_isa_pkg::xlen-1:0]       trace_pc,
  output logic                                 trace_wen,
  output logic [blimp_isa_pkg::reg_addr_w-1:0] trace_waddr,
  output logic [blimp_isa_pkg::xlen-1:0]       trace_wdata
);

  //--------------------------------------------------------------------------
  // Channels
  //--------------------------------------------------------------------------

  fetch_decode_if f2q (.clk(clk));
  fetch_decode_if q2x (.clk(clk));

  //--------------------------------------------------------------------------
  // Units
  //--------------------------------------------------------------------------

  fetch_unit #(
    .p_reset_pc (p_reset_pc)
  ) fetch_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_cyc (inst_cyc),
    .wb_stb (inst_stb),
    .wb_adr (inst_adr),
    .wb_dat (inst_dat),
    .wb_ack (inst_ack),
    .out    (f2q)
  );

  inst_queue #(
    .p_queue_depth (p_queue_depth)
  ) queue_i (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (f2q),
    .out   (q2x)
  );

  execute_commit_unit exec_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in          (q2x),
    .trace_val   (trace_val),
    .trace_pc    (trace_pc),
    .trace_wen   (trace_wen),
    .trace_waddr (trace_waddr),
    .trace_wdata (trace_wdata)
  );

endmodule

`default_nettype wire

// ==== source/blimp_isa_pkg.sv ====
// Blimp instruction set definitions
// Opcode encoding, instruction field positions, register and data widths

`default_nettype none

package blimp_isa_pkg;

  // Datapath and register file sizing
  localparam int xlen       = 32;
  localparam int reg_addr_w = 4;
  localparam int imm_w      = 16;

  // Opcodes, anything else commits without a write
  typedef enum logic [3:0] {
    op_nop  = 4'd0,
    op_add  = 4'd1,
    op_addi = 4'd2,
    op_mul  = 4'd3
  } opcode_e;

  // Field positions in the instruction word
  localparam int op_hi  = 31;
  localparam int op_lo  = 28;
  localparam int rd_hi  = 27;
  localparam int rd_lo  = 24;
  localparam int rs1_hi = 23;
  localparam int rs1_lo = 20;
  localparam int rs2_hi = 19;
  localparam int rs2_lo = 16;
  localparam int imm_hi = 15;
  localparam int imm_lo = 0;

endpackage

`default_nettype wire

// ==== source/blimp_uarch_pkg.sv ====
// Blimp microarchitecture definitions
// Execute FSM states and the fetched-instruction record

`default_nettype none

package blimp_uarch_pkg;

  // One fetched word and where it came from
  typedef struct packed {
    logic [blimp_isa_pkg::xlen-1:0] pc;
    logic [blimp_isa_pkg::xlen-1:0] inst;
  } fetch_rec_t;

  //--------------------------------------------------------------------------
  // Execute-commit FSM
  //--------------------------------------------------------------------------

  // Idle accepts, mul_busy finishes product, commit drives the trace
  typedef enum logic [1:0] {
    ex_idle     = 2'd0,
    ex_mul_busy = 2'd1,
    ex_commit   = 2'd2
  } exec_state_e;

endpackage

`default_nettype wire

// ==== source/execute_commit_unit.sv ====
// Blimp execute-commit unit
// Decodes one instruction at a time, reads the register file, runs the
// single-cycle ALU or two-cycle multiplier, writes back and drives the trace

`timescale 1ns/1ps
`default_nettype none

module execute_commit_unit (
  input  logic                                 clk,
  input  logic                                 rst_n,
  fetch_decode_if.cons                         in,
  output logic                                 trace_val,
  output logic [blimp_isa_pkg::xlen-1:0]       trace_pc,
  output logic                                 trace_wen,
  output logic [blimp_isa_pkg::reg_addr_w-1:0] trace_waddr,
  output logic [blimp_isa_pkg::xlen-1:0]       trace_wdata
);

  localparam int xlen   = blimp_isa_pkg::xlen;
  localparam int aw     = blimp_isa_pkg::reg_addr_w;
  localparam int half_w = xlen / 2;
  localparam int imm_w  = blimp_isa_pkg::imm_w;

  blimp_uarch_pkg::exec_state_e state;
  blimp_isa_pkg::opcode_e       opcode;

  logic [xlen-1:0]   rf [2**aw];
  logic [aw-1:0]     rd;
  logic [aw-1:0]     rs1;
  logic [aw-1:0]     rs2;
  logic [imm_w-1:0]  imm;
  logic [xlen-1:0]   rs1_val;
  logic [xlen-1:0]   rs2_val;
  logic [xlen-1:0]   alu_result;
  logic              alu_wen;
  logic              pop;
  logic [xlen-1:0]   pp_next;
  logic [xlen-1:0]   pp_q;
  logic [half_w-1:0] mul_alo_q;
  logic [half_w-1:0] mul_bhi_q;
  logic [half_w-1:0] hi_prod;
  logic [xlen-1:0]   mul_result;
  logic [xlen-1:0]   pc_q;
  logic [aw-1:0]     rd_q;
  logic [xlen-1:0]   wdata_q;
  logic              wen_q;

  //--------------------------------------------------------------------------
  // Decode and operand read
  //--------------------------------------------------------------------------

  assign opcode = blimp_isa_pkg::opcode_e'(
    in.rec.inst[blimp_isa_pkg::op_hi:blimp_isa_pkg::op_lo]);
  assign rd  = in.rec.inst[blimp_isa_pkg::rd_hi:blimp_isa_pkg::rd_lo];
  assign rs1 = in.rec.inst[blimp_isa_pkg::rs1_hi:blimp_isa_pkg::rs1_lo];
  assign rs2 = in.rec.inst[blimp_isa_pkg::rs2_hi:blimp_isa_pkg::rs2_lo];
  assign imm = in.rec.inst[blimp_isa_pkg::imm_hi:blimp_isa_pkg::imm_lo];

  // x0 is hardwired zero, never written
  assign rs1_val = (rs1 == '0) ? '0 : rf[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : rf[rs2];

  // Single-cycle ALU path
  always_comb begin
    alu_result = '0;
    case (opcode)
      blimp_isa_pkg::op_add:  alu_result = rs1_val + rs2_val;
      blimp_isa_pkg::op_addi: alu_result = rs1_val + {{(xlen-imm_w){imm[imm_w-1]}}, imm};
      default:                alu_result = '0;
    endcase
  end

  assign alu_wen = ((opcode == blimp_isa_pkg::op_add) ||
                    (opcode == blimp_isa_pkg::op_addi)) && (rd != '0);

  // Multiply split on the low half of rs2, upper half done next cycle
  assign pp_next    = rs1_val * {{half_w{1'b0}}, rs2_val[half_w-1:0]};
  assign hi_prod    = mul_alo_q * mul_bhi_q;
  assign mul_result = pp_q + {hi_prod, {half_w{1'b0}}};

  assign in.rdy = (state == blimp_uarch_pkg::ex_idle);
  assign pop    = in.val && in.rdy;

  //--------------------------------------------------------------------------
  // FSM
  //--------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= blimp_uarch_pkg::ex_idle;
      wen_q <= 1'b0;
    end else begin
      case (state)
        blimp_uarch_pkg::ex_idle: begin
          if (pop && (opcode == blimp_isa_pkg::op_mul)) begin
            state <= blimp_uarch_pkg::ex_mul_busy;
          end else if (pop) begin
            state <= blimp_uarch_pkg::ex_commit;
            wen_q <= alu_wen;
          end
        end
        blimp_uarch_pkg::ex_mul_busy: begin
          state <= blimp_uarch_pkg::ex_commit;
          wen_q <= (rd_q != '0);
        end
        blimp_uarch_pkg::ex_commit: begin
          state <= blimp_uarch_pkg::ex_idle;
          wen_q <= 1'b0;
        end
        default: state <= blimp_uarch_pkg::ex_idle;
      endcase
    end
  end

  // Writeback lands on the edge that raises trace_val
  always_ff @(posedge clk) begin
    if (pop) begin
      pc_q      <= in.rec.pc;
      rd_q      <= rd;
      wdata_q   <= alu_result;
      pp_q      <= pp_next;
      mul_alo_q <= rs1_val[half_w-1:0];
      mul_bhi_q <= rs2_val[xlen-1:half_w];
      if (alu_wen) rf[rd] <= alu_result;
    end
    if (state == blimp_uarch_pkg::ex_mul_busy) begin
      wdata_q <= mul_result;
      if (rd_q != '0) rf[rd_q] <= mul_result;
    end
  end

  assign trace_val   = (state == blimp_uarch_pkg::ex_commit);
  assign trace_pc    = pc_q;
  assign trace_wen   = wen_q;
  assign trace_waddr = rd_q;
  assign trace_wdata = wdata_q;

  a_wen_with_val: assert property (@(posedge clk) disable iff (!rst_n)
    trace_wen |-> trace_val);

  // Writes to x0 never reach the trace
  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
    trace_wen |-> (trace_waddr != '0));

endmodule

`default_nettype wire

// ==== source/fetch_decode_if.sv ====
// Valid/ready channel for one fetched instruction and its pc
// Producer holds rec while val is high and rdy is low

`timescale 1ns/1ps
`default_nettype none

interface fetch_decode_if (
  input logic clk
);

  logic                           val;
  logic                           rdy;
  blimp_uarch_pkg::fetch_rec_t    rec;

  // Sending side
  modport prod (input clk, output val, output rec, input rdy);

  // Receiving side
  modport cons (input clk, input val, input rec, output rdy);

endinterface

`default_nettype wire

// ==== source/fetch_unit.sv ====
// Blimp fetch unit
// Wishbone classic read master walking the pc, one fetch in flight,
// returned word held until the queue takes it

`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter logic [blimp_isa_pkg::xlen-1:0] p_reset_pc = '0
) (
  input  logic                           clk,
  input  logic                           rst_n,
  output logic                           wb_cyc,
  output logic                           wb_stb,
  output logic [blimp_isa_pkg::xlen-1:0] wb_adr,
  input  logic [blimp_isa_pkg::xlen-1:0] wb_dat,
  input  logic                           wb_ack,
  fetch_decode_if.prod                   out
);

  // Bus cycle running, or record waiting for the queue
  typedef enum logic {
    fs_bus,
    fs_hold
  } fetch_state_e;

  fetch_state_e                   state;
  logic                           cyc_q;
  logic [blimp_isa_pkg::xlen-1:0] pc;
  logic                           wb_done;
  blimp_uarch_pkg::fetch_rec_t    rec_q;

  assign wb_done = (state == fs_bus) && cyc_q && wb_ack;

  // Sequencer and pc
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= fs_bus;
      cyc_q <= 1'b0;
      pc    <= p_reset_pc;
    end else begin
      case (state)
        fs_bus: begin
          // First cycle out of reset opens the bus
          if (!cyc_q) begin
            cyc_q <= 1'b1;
          end else if (wb_ack) begin
            cyc_q <= 1'b0;
            state <= fs_hold;
          end
        end
        fs_hold: begin
          // Next fetch starts once the record is gone
          if (out.rdy) begin
            pc    <= pc + 32'd4;
            cyc_q <= 1'b1;
            state <= fs_bus;
          end
        end
        default: state <= fs_bus;
      endcase
    end
  end

  // Holding register for the returned word
  always_ff @(posedge clk) begin
    if (wb_done) begin
      rec_q.pc   <= pc;
      rec_q.inst <= wb_dat;
    end
  end

  assign wb_cyc  = cyc_q;
  assign wb_stb  = cyc_q;
  assign wb_adr  = pc;
  assign out.val = (state == fs_hold);
  assign out.rec = rec_q;

  //--------------------------------------------------------------------------
  // Bus protocol checks
  //--------------------------------------------------------------------------

  // Ack closes the bus cycle on the next edge
  a_drop_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_cyc && wb_ack) |=> (!wb_stb && !wb_cyc));

  // Request held until the slave answers
  a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)));

endmodule

`default_nettype wire

// ==== source/inst_queue.sv ====
// Blimp instruction queue
// Circular FIFO of fetched records between fetch and execute,
// push and pop allowed in the same cycle

`timescale 1ns/1ps
`default_nettype none

module inst_queue #(
  parameter int p_queue_depth = 4
) (
  input  logic         clk,
  input  logic         rst_n,
  fetch_decode_if.cons in,
  fetch_decode_if.prod out
);

  localparam int idx_w = $clog2(p_queue_depth);

  blimp_uarch_pkg::fetch_rec_t mem [p_queue_depth];

  // Extra top bit tells full from empty
  logic [idx_w:0] wr_ptr;
  logic [idx_w:0] rd_ptr;
  logic [idx_w:0] count;
  logic           full;
  logic           empty;
  logic           push;
  logic           pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[idx_w] != rd_ptr[idx_w]) &&
                 (wr_ptr[idx_w-1:0] == rd_ptr[idx_w-1:0]);

  // Entries held, from the pointer distance
  assign count = wr_ptr - rd_ptr;

  assign push = in.val && in.rdy;
  assign pop  = out.val && out.rdy;

  // Pointers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[idx_w-1:0]] <= in.rec;
    end
  end

  // Head entry straight out of the array
  assign in.rdy  = !full;
  assign out.val = !empty;
  assign out.rec = mem[rd_ptr[idx_w-1:0]];

  //--------------------------------------------------------------------------
  // Occupancy checks
  //--------------------------------------------------------------------------

  // A push into a full queue overflows the count
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |=> (count <= p_queue_depth));

  // A pop from an empty queue wraps the count
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |=> (count < p_queue_depth));

endmodule

`default_nettype wire
